//--- Makefile
# Verilator build and run of the housekeeping testbench

SIM       = verilator
TOP       = tb_cl_housekeeping
FILELIST  = cl_housekeeping.f
SIM_FLAGS = --binary --timing --timescale 1ns/100ps --top-module $(TOP)
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Testbench passed

SOURCES   = $(filter-out +%,$(shell cat $(FILELIST))) verilog/cl_housekeeping_defines.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/cl_housekeeping_check.sv
/*
 Checker for the housekeeping top level. Samples all ports on the rising
 edge, keeps delayed copies of the inputs and compares every output each
 cycle while reset is released. Mismatches are counted.
*/
`timescale 1ns/100ps
`include "cl_housekeeping_defines.svh"

module cl_housekeeping_check
   import cl_housekeeping_pkg::*;
(
   input  logic                    clk,
   input  logic                    sync_rst_n,
   input  logic [31:0]             ctl0,
   input  logic [2:0]              ddr_local_ready,
   input  logic                    ddr_c_ready,
   input  scrb_status_t            scrb_status [`CL_NUM_SCRB],
   input  logic                    flr_assert,
   input  logic [`CL_NUM_SCRB-1:0] scrb_enable,
   input  logic [31:0]             status0,
   input  logic [31:0]             status1,
   input  logic [31:0]             id0,
   input  logic [31:0]             id1,
   input  logic                    flr_done,
   input  stat_req_t               stat_req_in  [`CL_NUM_DDR_STAT],
   input  stat_req_t               stat_req_out [`CL_NUM_DDR_STAT],
   input  stat_ack_t               stat_ack_in  [`CL_NUM_DDR_STAT],
   input  stat_ack_t               stat_ack_out [`CL_NUM_DDR_STAT],
   output int                      error_count,
   output int                      check_count
);

   localparam int STAGES = `CL_STAT_PIPE_STAGES;

   int           errors = 0;
   int           checks = 0;

   // Registered inputs read as zero for an edge taken in reset
   logic [31:0]  ctl0_d1 = '0;
   logic [31:0]  ctl0_d2 = '0;
   logic         c_ready_d1 = 1'b0;
   logic         c_ready_d2 = 1'b0;
   logic         flr_d1 = 1'b0;
   logic         flr_done_exp = 1'b0;
   logic [2:0]   local_ready_d1 = '0;
   scrb_status_t scrb_d1 [`CL_NUM_SCRB];

   // Entry 0 holds the newest statistics input
   stat_req_t    req_hist [STAGES][`CL_NUM_DDR_STAT];
   stat_ack_t    ack_hist [STAGES][`CL_NUM_DDR_STAT];

   assign error_count = errors;
   assign check_count = checks;

   task automatic compare_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("** Error: %s expected %h, actual %h at %0t ns",
                  name, expected, actual, $time);
      end
   endtask

   task automatic check_control();
      logic [3:0]  ready_exp;
      logic [3:0]  done_exp;
      logic [31:0] status_exp;
      logic [63:0] addr_exp;
      logic [2:0]  sel;
      int          slot;
      ready_exp = {c_ready_d2, local_ready_d1};
      for (int i = 0; i < `CL_NUM_SCRB; i++)
      begin
         done_exp[i] = scrb_d1[i].done;
      end
      sel  = ctl0_d2[30:28];
      slot = (sel >= 3'd1 && sel <= 3'd3) ? int'(sel) : 0;
      addr_exp = scrb_d1[slot].addr;
      if (ctl0_d2[31])
      begin
         status_exp = {1'b0, scrb_d1[3].state, 1'b0, scrb_d1[2].state,
                       1'b0, scrb_d1[1].state, 1'b0, scrb_d1[0].state,
                       8'h00, done_exp, ready_exp};
         compare_value("id0", 64'(addr_exp[31:0]), 64'(id0));
         compare_value("id1", 64'(addr_exp[63:32]), 64'(id1));
      end
      else
      begin
         status_exp = {`CL_STATUS_TAG, 4'h0, done_exp, ready_exp};
         compare_value("id0", 64'(`CL_ID0), 64'(id0));
         compare_value("id1", 64'(`CL_ID1), 64'(id1));
      end
      compare_value("status0", 64'(status_exp), 64'(status0));
      compare_value("status1", 64'(`CL_VERSION), 64'(status1));
      compare_value("scrb_enable", 64'(ctl0_d1[3:0]), 64'(scrb_enable));
      compare_value("flr_done", 64'(flr_done_exp), 64'(flr_done));
   endtask

   task automatic check_statistics();
      for (int n = 0; n < `CL_NUM_DDR_STAT; n++)
      begin
         compare_value($sformatf("stat_req_out[%0d]", n),
                       64'(req_hist[STAGES-1][n]), 64'(stat_req_out[n]));
         compare_value($sformatf("stat_ack_out[%0d]", n),
                       64'(ack_hist[STAGES-1][n]), 64'(stat_ack_out[n]));
      end
   endtask

   task automatic update_model();
      // Done rises when a request is seen while done is low
      flr_done_exp   = sync_rst_n ? (flr_d1 && !flr_done_exp) : 1'b0;
      flr_d1         = sync_rst_n ? flr_assert : 1'b0;
      ctl0_d2        = ctl0_d1;
      ctl0_d1        = sync_rst_n ? ctl0 : 32'h0;
      c_ready_d2     = c_ready_d1;
      c_ready_d1     = sync_rst_n ? ddr_c_ready : 1'b0;
      local_ready_d1 = ddr_local_ready;
      scrb_d1        = scrb_status;
      if (!sync_rst_n)
      begin
         for (int s = 0; s < STAGES; s++)
         begin
            for (int n = 0; n < `CL_NUM_DDR_STAT; n++)
            begin
               req_hist[s][n] = '0;
               ack_hist[s][n] = '0;
            end
         end
      end
      else
      begin
         for (int s = STAGES - 1; s > 0; s--)
         begin
            req_hist[s] = req_hist[s-1];
            ack_hist[s] = ack_hist[s-1];
         end
         req_hist[0] = stat_req_in;
         ack_hist[0] = stat_ack_in;
      end
   endtask

   always @(posedge clk)
   begin
      if (sync_rst_n)
      begin
         check_control();
         check_statistics();
      end
      update_model();
   end

endmodule

//--- bench/tb_cl_housekeeping.sv
/*
 Testbench for the housekeeping top level. Inputs change on the rising
 edge from a seeded $random stream; the debug bit of ctl0 follows long
 phases. All comparing happens in the checker module.
*/
`timescale 1ns/100ps
`include "cl_housekeeping_defines.svh"

module tb_cl_housekeeping
   import cl_housekeeping_pkg::*;
;

   localparam int CLK_PERIOD    = 40;
   localparam int RESET_CYCLES  = 4;
   localparam int NUM_CYCLES    = 2000;
   localparam int DEBUG_STRETCH = 250;
   localparam int TIMEOUT_NS    = (RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD;

   logic                    clk;
   logic                    sync_rst_n;

   logic [31:0]             ctl0;
   logic [2:0]              ddr_local_ready;
   logic                    ddr_c_ready;
   scrb_status_t            scrb_status [`CL_NUM_SCRB];
   logic                    flr_assert;

   logic [`CL_NUM_SCRB-1:0] scrb_enable;
   logic [31:0]             status0;
   logic [31:0]             status1;
   logic [31:0]             id0;
   logic [31:0]             id1;
   logic                    flr_done;

   stat_req_t               stat_req_in  [`CL_NUM_DDR_STAT];
   stat_req_t               stat_req_out [`CL_NUM_DDR_STAT];
   stat_ack_t               stat_ack_in  [`CL_NUM_DDR_STAT];
   stat_ack_t               stat_ack_out [`CL_NUM_DDR_STAT];

   int                      error_count;
   int                      check_count;

   integer                  seed = 32'ha076_b884;
   // Cycles left in the current FLR request
   int                      flr_left = 0;

   cl_housekeeping i_cl_housekeeping
   (
      .clk             (clk),
      .sync_rst_n      (sync_rst_n),
      .ctl0            (ctl0),
      .ddr_local_ready (ddr_local_ready),
      .ddr_c_ready     (ddr_c_ready),
      .scrb_status     (scrb_status),
      .flr_assert      (flr_assert),
      .scrb_enable     (scrb_enable),
      .status0         (status0),
      .status1         (status1),
      .id0             (id0),
      .id1             (id1),
      .flr_done        (flr_done),
      .stat_req_in     (stat_req_in),
      .stat_req_out    (stat_req_out),
      .stat_ack_in     (stat_ack_in),
      .stat_ack_out    (stat_ack_out)
   );

   cl_housekeeping_check i_cl_housekeeping_check
   (
      .clk             (clk),
      .sync_rst_n      (sync_rst_n),
      .ctl0            (ctl0),
      .ddr_local_ready (ddr_local_ready),
      .ddr_c_ready     (ddr_c_ready),
      .scrb_status     (scrb_status),
      .flr_assert      (flr_assert),
      .scrb_enable     (scrb_enable),
      .status0         (status0),
      .status1         (status1),
      .id0             (id0),
      .id1             (id1),
      .flr_done        (flr_done),
      .stat_req_in     (stat_req_in),
      .stat_req_out    (stat_req_out),
      .stat_ack_in     (stat_ack_in),
      .stat_ack_out    (stat_ack_out),
      .error_count     (error_count),
      .check_count     (check_count)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // One cycle of random stimulus, applied on the current rising edge
   task automatic drive_inputs(input int cycle);
      logic        dbg_phase;
      logic [31:0] ctl_rnd;
      logic [31:0] misc_rnd;
      logic [95:0] scrb_rnd;
      logic [63:0] stat_rnd;
      dbg_phase = ((cycle / DEBUG_STRETCH) % 2) == 1;
      ctl_rnd   = $random(seed);
      misc_rnd  = $random(seed);
      ctl0            <= {dbg_phase, ctl_rnd[30:0]};
      ddr_local_ready <= misc_rnd[2:0];
      ddr_c_ready     <= misc_rnd[3];
      for (int i = 0; i < `CL_NUM_SCRB; i++)
      begin
         scrb_rnd = {$random(seed), $random(seed), $random(seed)};
         scrb_status[i] <= scrb_rnd[67:0];
      end
      for (int n = 0; n < `CL_NUM_DDR_STAT; n++)
      begin
         stat_rnd = {$random(seed), $random(seed)};
         stat_req_in[n] <= stat_rnd[41:0];
         stat_rnd = {$random(seed), $random(seed)};
         stat_ack_in[n] <= stat_rnd[40:0];
      end
      // Mix of single-cycle and held FLR requests
      if (flr_left > 0)
      begin
         flr_assert <= 1'b1;
         flr_left--;
      end
      else
      begin
         flr_assert <= 1'b0;
         if (misc_rnd[7:4] == 4'd0)
         begin
            flr_left = misc_rnd[8] ? 1 : 3 + int'(misc_rnd[11:9]);
         end
      end
   endtask

   initial
   begin
      sync_rst_n      = 1'b0;
      ctl0            = '0;
      ddr_local_ready = '0;
      ddr_c_ready     = 1'b0;
      flr_assert      = 1'b0;
      for (int i = 0; i < `CL_NUM_SCRB; i++)
      begin
         scrb_status[i] = '0;
      end
      for (int n = 0; n < `CL_NUM_DDR_STAT; n++)
      begin
         stat_req_in[n] = '0;
         stat_ack_in[n] = '0;
      end

      // Inputs keep changing while reset is held
      repeat (RESET_CYCLES - 1)
      begin
         @(posedge clk);
         drive_inputs(0);
      end
      @(posedge clk);
      sync_rst_n <= 1'b1;
      for (int cycle = 0; cycle < NUM_CYCLES; cycle++)
      begin
         drive_inputs(cycle);
         @(posedge clk);
      end

      // Let the last values leave the pipelines
      repeat (`CL_STAT_PIPE_STAGES + 2) @(posedge clk);
      @(negedge clk);
      $display("Checks: %0d  Errors: %0d", check_count, error_count);
      if (error_count == 0 && check_count > 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("Timeout: the stimulus did not finish in %0d ns", TIMEOUT_NS);
      $display("Testbench failed");
      $finish;
   end

endmodule

//--- cl_housekeeping.f
+incdir+verilog
verilog/cl_housekeeping_pkg.sv
verilog/stat_pipe.sv
verilog/ctl_status.sv
verilog/cl_housekeeping.sv
bench/cl_housekeeping_check.sv
bench/tb_cl_housekeeping.sv

//--- verilog/cl_housekeeping.sv
/*
 Housekeeping top level. Control and status come from one registered
 stage; each statistics channel is carried by a request pipe and an
 acknowledge pipe of `CL_STAT_PIPE_STAGES cycles. No back-pressure.
*/
`timescale 1ns/100ps
`include "cl_housekeeping_defines.svh"

module cl_housekeeping
   import cl_housekeeping_pkg::*;
(
   input  logic                    clk,
   input  logic                    sync_rst_n,

   // Shell control and status
   input  logic [31:0]             ctl0,
   input  logic [2:0]              ddr_local_ready,
   input  logic                    ddr_c_ready,
   input  scrb_status_t            scrb_status [`CL_NUM_SCRB],
   input  logic                    flr_assert,

   output logic [`CL_NUM_SCRB-1:0] scrb_enable,
   output logic [31:0]             status0,
   output logic [31:0]             status1,
   output logic [31:0]             id0,
   output logic [31:0]             id1,
   output logic                    flr_done,

   // DDR statistics
   input  stat_req_t               stat_req_in  [`CL_NUM_DDR_STAT],
   output stat_req_t               stat_req_out [`CL_NUM_DDR_STAT],
   input  stat_ack_t               stat_ack_in  [`CL_NUM_DDR_STAT],
   output stat_ack_t               stat_ack_out [`CL_NUM_DDR_STAT]
);

   // ------------------------------------------------------------------------
   // Control and status
   // ------------------------------------------------------------------------

   ctl_status i_ctl_status
   (
      .clk             (clk),
      .sync_rst_n      (sync_rst_n),

      .ctl0            (ctl0),
      .ddr_local_ready (ddr_local_ready),
      .ddr_c_ready     (ddr_c_ready),
      .scrb_status     (scrb_status),
      .flr_assert      (flr_assert),

      .scrb_enable     (scrb_enable),
      .status0         (status0),
      .status1         (status1),
      .id0             (id0),
      .id1             (id1),
      .flr_done        (flr_done)
   );

   // ------------------------------------------------------------------------
   // Statistics pipelines
   // ------------------------------------------------------------------------

   for (genvar g = 0; g < `CL_NUM_DDR_STAT; g++)
   begin : g_stat

      // Shell toward controller
      stat_pipe
      #(
         .payload_t (stat_req_t),
         .STAGES    (`CL_STAT_PIPE_STAGES)
      )
      i_req_pipe
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_data    (stat_req_in[g]),
         .out_data   (stat_req_out[g])
      );

      // Controller toward shell
      stat_pipe
      #(
         .payload_t (stat_ack_t),
         .STAGES    (`CL_STAT_PIPE_STAGES)
      )
      i_ack_pipe
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_data    (stat_ack_in[g]),
         .out_data   (stat_ack_out[g])
      );

   end

endmodule

//--- verilog/cl_housekeeping_defines.svh
/*
 Constants shared by the housekeeping block. The version word is a fixed
 value here; change it in this file when a new image is built.
 Slot order of all per-scrubber vectors is A, B, D, C.
*/
`ifndef CL_HOUSEKEEPING_DEFINES_SVH
`define CL_HOUSEKEEPING_DEFINES_SVH

// Version word returned on status1
`define CL_VERSION 32'hee_ee_ee_00

// Fixed ID words shown while debug is off
`define CL_ID0 32'h1d50_6789
`define CL_ID1 32'h1d51_fedc

// Upper 20 bits of the normal status word
`define CL_STATUS_TAG 20'ha111_1

// Register stages on each statistics path
`define CL_STAT_PIPE_STAGES 4

// Channel and scrubber counts
`define CL_NUM_DDR_STAT 3
`define CL_NUM_SCRB 4

// Field widths
`define CL_STAT_ADDR_W 8
`define CL_STAT_DATA_W 32
`define CL_SCRB_ADDR_W 64

`endif

//--- verilog/cl_housekeeping_pkg.sv
/*
 Payload types for the housekeeping block. Field order inside each struct
 matches the bit order of the shell's flat statistics buses, first field
 in the most significant bits.
*/
`include "cl_housekeeping_defines.svh"

package cl_housekeeping_pkg;

   // -------------------------------------------------------------------------
   // DDR statistics, shell toward controller
   // -------------------------------------------------------------------------

   // 1 + 1 + 8 + 32 = 42 bits
   typedef struct packed
   {
      logic                        wr;
      logic                        rd;
      logic [`CL_STAT_ADDR_W-1:0]  addr;
      logic [`CL_STAT_DATA_W-1:0]  wdata;
   } stat_req_t;

   // -------------------------------------------------------------------------
   // DDR statistics, controller toward shell
   // -------------------------------------------------------------------------

   // 1 + 8 + 32 = 41 bits
   typedef struct packed
   {
      logic                        ack;
      // Interrupt status from the controller
      logic [7:0]                  intr;
      logic [`CL_STAT_DATA_W-1:0]  rdata;
   } stat_ack_t;

   // -------------------------------------------------------------------------
   // Scrubber report
   // -------------------------------------------------------------------------

   // 3 + 1 + 64 = 68 bits
   typedef struct packed
   {
      // Scrubber FSM state, shown in the debug status view
      logic [2:0]                  state;
      logic                        done;
      // Address being scrubbed
      logic [`CL_SCRB_ADDR_W-1:0]  addr;
   } scrb_status_t;

endpackage

//--- verilog/ctl_status.sv
/*
 Control word decode, status and ID words, and the FLR answer.
 status0, id0 and id1 have no reset and settle on the first clock.
 Debug select values above 3 show slot 0. flr_done toggles while the
 request is held.
*/
`timescale 1ns/100ps
`include "cl_housekeeping_defines.svh"

module ctl_status
   import cl_housekeeping_pkg::*;
(
   input  logic                    clk,
   input  logic                    sync_rst_n,

   input  logic [31:0]             ctl0,
   input  logic [2:0]              ddr_local_ready,
   input  logic                    ddr_c_ready,
   input  scrb_status_t            scrb_status [`CL_NUM_SCRB],
   input  logic                    flr_assert,

   output logic [`CL_NUM_SCRB-1:0] scrb_enable,
   output logic [31:0]             status0,
   output logic [31:0]             status1,
   output logic [31:0]             id0,
   output logic [31:0]             id1,
   output logic                    flr_done
);

   logic [31:0]                ctl0_q;
   logic                       ddr_c_ready_q;
   logic                       flr_assert_q;

   logic                       dbg_en;
   logic [2:0]                 dbg_sel;

   logic [`CL_NUM_SCRB-1:0]    ready_vec;
   logic [`CL_NUM_SCRB-1:0]    done_vec;
   logic [`CL_SCRB_ADDR_W-1:0] sel_addr;

   // ------------------------------------------------------------------------
   // Input registers
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl0_q        <= '0;
         ddr_c_ready_q <= 1'b0;
         flr_assert_q  <= 1'b0;
      end
      else
      begin
         ctl0_q        <= ctl0;
         ddr_c_ready_q <= ddr_c_ready;
         flr_assert_q  <= flr_assert;
      end
   end

   // ------------------------------------------------------------------------
   // Control word decode
   // ------------------------------------------------------------------------

   // Bits 3..0 enable scrubbers C, D, B, A
   assign scrb_enable = ctl0_q[`CL_NUM_SCRB-1:0];

   // Bit 31 switches status and ID words to the debug view
   assign dbg_en  = ctl0_q[31];
   assign dbg_sel = ctl0_q[30:28];

   // Local controllers fill slots 0 to 2, the shell's C channel slot 3
   assign ready_vec = {ddr_c_ready_q, ddr_local_ready};

   always_comb
   begin
      for (int i = 0; i < `CL_NUM_SCRB; i++)
      begin
         done_vec[i] = scrb_status[i].done;
      end
   end

   // Address shown on the ID words in debug mode
   always_comb
   begin
      case (dbg_sel)
         3'd1:    sel_addr = scrb_status[1].addr;
         3'd2:    sel_addr = scrb_status[2].addr;
         3'd3:    sel_addr = scrb_status[3].addr;
         default: sel_addr = scrb_status[0].addr;
      endcase
   end

   // ------------------------------------------------------------------------
   // Status and ID words
   // ------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (dbg_en)
      begin
         // One nibble per slot, slot 3 in the top byte
         status0 <= {1'b0, scrb_status[3].state,
                     1'b0, scrb_status[2].state,
                     1'b0, scrb_status[1].state,
                     1'b0, scrb_status[0].state,
                     8'd0, done_vec, ready_vec};
         id0     <= sel_addr[31:0];
         id1     <= sel_addr[63:32];
      end
      else
      begin
         status0 <= {`CL_STATUS_TAG, 4'd0, done_vec, ready_vec};
         id0     <= `CL_ID0;
         id1     <= `CL_ID1;
      end
   end

   assign status1 = `CL_VERSION;

   // ------------------------------------------------------------------------
   // Function level reset answer
   // ------------------------------------------------------------------------

   // One-cycle done per request edge; a held request gives a pulse train
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_done <= 1'b0;
      end
      else
      begin
         flr_done <= flr_assert_q && !flr_done;
      end
   end

endmodule

//--- verilog/stat_pipe.sv
/*
 Fixed-depth register pipeline, STAGES >= 1. Every stage is cleared by
 reset, so the output reads zero until the first value has passed through.
 No stall; a new value is taken every cycle.
*/
`timescale 1ns/100ps

module stat_pipe
#(
   parameter type payload_t = logic,
   parameter int  STAGES    = 1
)
(
   input  logic     clk,
   input  logic     sync_rst_n,

   input  payload_t in_data,
   output payload_t out_data
);

   // Stage 0 takes the input, the last stage drives the output
   payload_t pipe_q [STAGES];

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            pipe_q[i] <= '0;
         end
      end
      else
      begin
         pipe_q[0] <= in_data;
         for (int i = 1; i < STAGES; i++)
         begin
            pipe_q[i] <= pipe_q[i-1];
         end
      end
   end

   assign out_data = pipe_q[STAGES-1];

endmodule
